//--- Bender.yml
package:
  name: fetch_front_end

export_include_dirs:
  - source

sources:
  - source/frontPkg.sv
  - source/pcUnit.sv
  - source/ifIdReg.sv
  - source/branchDecoder.sv
  - source/fetchFrontEnd.sv
  - target: test
    files:
      - verif/fetchFrontEnd_props.sv
      - verif/fetchFrontEnd_tb.sv

//--- all.f
+incdir+source
source/frontPkg.sv
source/pcUnit.sv
source/ifIdReg.sv
source/branchDecoder.sv
source/fetchFrontEnd.sv
verif/fetchFrontEnd_props.sv
verif/fetchFrontEnd_tb.sv

//--- source/branchDecoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "front_params.svh"

module branchDecoder (
	input wire logic clk,
	input wire logic rst,
	input wire logic stall,
	input wire logic flush,
	input wire frontPkg::fetchEntryT idEntry,
	input wire logic idValid,
	output logic redirect,
	output frontPkg::addrT redirectTarget,
	output frontPkg::decodedT decoded
);
	import frontPkg::*;

	instrT ir; // instruction in ID
	logic [`FRONT_OP_W-1:0] opcode;
	regIdxT rs;
	regIdxT rt;
	regIdxT rd;
	logic [31:0] imm32;
	addrT seqPc; // PC of the delay slot
	addrT jumpTarget; // J and JAL region target
	addrT branchTarget; // PC relative target of beq
	logic isJ;
	logic isJal;
	logic isB;
	logic takeJump; // this entry changes control flow
	logic inDelaySlot; // last accepted instruction was a jump
	decodedT decNext;

	assign ir = idEntry.instr;
	assign opcode = ir[31:32-`FRONT_OP_W];
	assign rs = rsOf(ir);
	assign rt = rtOf(ir);
	assign rd = rdOf(ir);
	assign imm32 = {{16{ir[15]}}, ir[15:0]};

	assign seqPc = idEntry.pc + addrT'(`FRONT_INSTR_BYTES);
	assign jumpTarget = {seqPc[31:28], ir[25:0], 2'b00}; // stays in the 256 MB region
	assign branchTarget = seqPc + {imm32[29:0], 2'b00};

	assign isJ = opcode == `FRONT_OP_J;
	assign isJal = opcode == `FRONT_OP_JAL;
	// beq $zero,$zero is the assembler's unconditional b
	assign isB = (opcode == `FRONT_OP_BEQ) && (rs == '0) && (rt == '0);

	// a faulting fetch never steers the PC
	assign takeJump = idValid && !idEntry.adEL && (isJ || isJal || isB);

	assign redirect = takeJump;
	assign redirectTarget = isB ? branchTarget : jumpTarget;

	// The instruction after a jump is already being fetched when the jump is
	// resolved, so it is the delay slot. Only accepted entries move the flag
	always_ff @(posedge clk) begin
		if (!rst || flush) begin
			inDelaySlot <= 1'b0;
		end else if (!stall && idValid) begin
			inDelaySlot <= takeJump;
		end
	end

	always_comb begin
		decNext = '0;
		if (idValid) begin
			decNext.valid = 1'b1;
			decNext.pc = idEntry.pc;
			decNext.instr = ir;
			decNext.rs = rs;
			decNext.rt = rt;
			decNext.rd = rd;
			decNext.imm32 = imm32;
			decNext.isJump = takeJump;
			decNext.isLink = takeJump && isJal;
			decNext.isBD = inDelaySlot;
			decNext.adEL = idEntry.adEL;
		end
	end

	// ID/EX style register that clears on flush and holds on stall
	always_ff @(posedge clk) begin
		if (!rst || flush) begin
			decoded <= '0;
		end else if (!stall) begin
			decoded <= decNext;
		end
	end

endmodule

`default_nettype wire

//--- source/fetchFrontEnd.sv
`timescale 1ns/100ps
`default_nettype none

module fetchFrontEnd (
	input wire logic clk,
	input wire logic rst,
	input wire logic stall, // freezes all three stages
	input wire logic flush, // one cycle pulse, wins over stall
	input wire frontPkg::addrT flushTarget,
	input wire frontPkg::instrT instr, // combinational reply to instrAddr
	output frontPkg::addrT instrAddr,
	output frontPkg::decodedT decoded
);
	import frontPkg::*;

	addrT pc; // current fetch address
	logic adEL; // current fetch address is misaligned
	fetchEntryT fetchEntry; // IF stage result
	fetchEntryT idEntry; // word held in ID
	logic idValid;
	logic redirect; // jump resolved in ID
	addrT redirectTarget;

	pcUnit pcUnit_i (
		.clk (clk),
		.rst (rst),
		.stall (stall),
		.flush (flush),
		.flushTarget (flushTarget),
		.redirect (redirect),
		.redirectTarget (redirectTarget),
		.pc (pc),
		.adEL (adEL)
	);

	assign instrAddr = pc;

	// memory answers in the same cycle, so the word pairs with the current PC
	assign fetchEntry = '{pc: pc, instr: instr, adEL: adEL};

	ifIdReg ifIdReg_i (
		.clk (clk),
		.rst (rst),
		.stall (stall),
		.flush (flush),
		.fetchEntry (fetchEntry),
		.idEntry (idEntry),
		.idValid (idValid)
	);

	branchDecoder branchDecoder_i (
		.clk (clk),
		.rst (rst),
		.stall (stall),
		.flush (flush),
		.idEntry (idEntry),
		.idValid (idValid),
		.redirect (redirect),
		.redirectTarget (redirectTarget),
		.decoded (decoded)
	);

endmodule

`default_nettype wire

//--- source/frontPkg.sv
`default_nettype none

package frontPkg;

	typedef logic [31:0] addrT; // byte address
	typedef logic [31:0] instrT; // raw instruction word
	typedef logic [4:0] regIdxT; // GPR index

	// one fetched word as it enters the IF/ID register
	typedef struct packed {
		addrT pc; // address the word was fetched from
		instrT instr; // word returned by the instruction memory
		logic adEL; // fetch address was not word aligned
	} fetchEntryT;

	// decode stage result handed to the rest of the pipeline
	typedef struct packed {
		logic valid; // entry holds a real instruction
		addrT pc; // PC of this instruction
		instrT instr; // zero when adEL is set
		regIdxT rs; // bits 25..21
		regIdxT rt; // bits 20..16
		regIdxT rd; // bits 15..11
		logic [31:0] imm32; // sign extended bits 15..0
		logic isJump; // J, JAL or beq $zero,$zero taken here
		logic isLink; // JAL writes PC plus 8 to $ra further down
		logic isBD; // sits in the delay slot of the previous jump
		logic adEL; // address error on fetch
	} decodedT;

	// the decoder takes its register fields from these slices of a MIPS word
	function automatic regIdxT rsOf(instrT word);
		return word[25:21];
	endfunction

	function automatic regIdxT rtOf(instrT word);
		return word[20:16];
	endfunction

	function automatic regIdxT rdOf(instrT word);
		return word[15:11];
	endfunction

endpackage

`default_nettype wire

//--- source/front_params.svh
`ifndef FRONT_PARAMS_SVH
`define FRONT_PARAMS_SVH

// first fetch address after reset is the MIPS boot ROM entry point
`define FRONT_RESET_VEC 32'hbfc0_0000

// instruction word size and the PC step it implies
`define FRONT_INSTR_W 32
`define FRONT_INSTR_BYTES (`FRONT_INSTR_W / 8)

// major opcode field in bits 31..26
`define FRONT_OP_W 6

// opcodes resolved without register values
`define FRONT_OP_J   6'd2
`define FRONT_OP_JAL 6'd3
`define FRONT_OP_BEQ 6'd4

`endif

//--- source/ifIdReg.sv
`timescale 1ns/100ps
`default_nettype none

module ifIdReg (
	input wire logic clk,
	input wire logic rst,
	input wire logic stall,
	input wire logic flush,
	input wire frontPkg::fetchEntryT fetchEntry,
	output frontPkg::fetchEntryT idEntry,
	output logic idValid
);
	import frontPkg::*;

	fetchEntryT loadEntry; // entry as it will be stored

	// a fetch from a misaligned PC keeps its address and flag but not its word,
	// so nothing downstream can decode a jump out of it
	always_comb begin
		loadEntry = fetchEntry;
		if (fetchEntry.adEL) begin
			loadEntry.instr = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst || flush) begin
			idEntry <= '0;
		end else if (!stall) begin
			idEntry <= loadEntry;
		end
	end

	// every word fetched while the pipe moves is a real instruction
	always_ff @(posedge clk) begin
		if (!rst || flush) begin
			idValid <= 1'b0;
		end else if (!stall) begin
			idValid <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- source/pcUnit.sv
`timescale 1ns/100ps
`default_nettype none

`include "front_params.svh"

module pcUnit (
	input wire logic clk,
	input wire logic rst,
	input wire logic stall,
	input wire logic flush,
	input wire frontPkg::addrT flushTarget,
	input wire logic redirect,
	input wire frontPkg::addrT redirectTarget,
	output frontPkg::addrT pc,
	output logic adEL
);
	import frontPkg::*;

	addrT seqPc; // fall-through address
	addrT nextPc; // address loaded on the next edge
	logic nextAdEL; // misalignment of nextPc
	logic pcWr; // PC register write enable

	assign seqPc = pc + addrT'(`FRONT_INSTR_BYTES);

	// flush comes from exception entry and beats a jump in ID
	always_comb begin
		if (flush) begin
			nextPc = flushTarget;
		end else if (redirect) begin
			nextPc = redirectTarget; // jump resolved in ID this cycle
		end else begin
			nextPc = seqPc;
		end
	end

	assign nextAdEL = |nextPc[1:0]; // words must sit on a 4 byte boundary

	// a stall freezes fetch, but a flush still has to land
	assign pcWr = flush || !stall;

	always_ff @(posedge clk) begin
		if (!rst) begin
			pc <= `FRONT_RESET_VEC;
		end else if (pcWr) begin
			pc <= nextPc;
		end
	end

	// the flag is registered with the PC so both describe the same fetch
	always_ff @(posedge clk) begin
		if (!rst) begin
			adEL <= 1'b0; // reset vector is aligned
		end else if (pcWr) begin
			adEL <= nextAdEL;
		end
	end

endmodule

`default_nettype wire

//--- verif/fetchFrontEnd_props.sv
`timescale 1ns/100ps
`default_nettype none

`include "front_params.svh"

module fetchFrontEnd_props (
	input wire logic clk,
	input wire logic rst,
	input wire logic stall,
	input wire logic flush,
	input wire frontPkg::addrT flushTarget,
	input wire frontPkg::addrT instrAddr,
	input wire frontPkg::decodedT decoded
);
	import frontPkg::*;

	int failCount = 0; // number of failed assertions so far

	// reset loads the boot vector and leaves nothing to decode
	resetState: assert property (@(posedge clk)
		!rst |=> instrAddr == `FRONT_RESET_VEC && decoded == '0) else begin
		failCount++;
		$error("reset did not load the boot vector or clear decoded");
	end

	stallHold: assert property (@(posedge clk)
		rst && stall && !flush |=> $stable(instrAddr) && $stable(decoded)) else begin
		failCount++;
		$error("instrAddr or decoded changed during a stall");
	end

	// flush lands even when the stall is high
	flushLand: assert property (@(posedge clk)
		rst && flush |=> instrAddr == $past(flushTarget) && !decoded.valid) else begin
		failCount++;
		$error("flush did not redirect fetch or clear decoded.valid");
	end

	adELQuiet: assert property (@(posedge clk)
		decoded.valid && decoded.adEL |-> decoded.instr == '0 && !decoded.isJump) else begin
		failCount++;
		$error("an address error entry carried an instruction or a jump");
	end

endmodule

bind fetchFrontEnd fetchFrontEnd_props props_i (
	.clk (clk),
	.rst (rst),
	.stall (stall),
	.flush (flush),
	.flushTarget (flushTarget),
	.instrAddr (instrAddr),
	.decoded (decoded)
);

`default_nettype wire

//--- verif/fetchFrontEnd_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "front_params.svh"

module fetchFrontEnd_tb;
	import frontPkg::*;

	localparam int MaxCycles = 400; // about twice the length of the whole sequence

	logic clk;
	logic rst;
	logic stall;
	logic flush;
	addrT flushTarget;
	instrT instr;
	addrT instrAddr;
	decodedT decoded;

	instrT mem [256]; // aliased over the address space by bits 9..2
	logic [31:0] lcgState = 32'd97086;
	int cycles = 0;
	int seenJump = 0;
	int seenLink = 0;
	int seenBD = 0;
	int seenAdEL = 0;
	int seenPlainBeq = 0; // beq on real registers that is never taken

	addrT mPc; // reference model of the fetch address
	logic mIdValid;
	addrT mIdPc;
	instrT mIdWord; // zero for a misaligned fetch
	logic mIdAdEL;
	logic mBD; // previous accepted ID entry was a jump
	decodedT expDec;

	fetchFrontEnd dut_i (
		.clk (clk),
		.rst (rst),
		.stall (stall),
		.flush (flush),
		.flushTarget (flushTarget),
		.instr (instr),
		.instrAddr (instrAddr),
		.decoded (decoded)
	);

	assign instr = mem[instrAddr[9:2]]; // combinational instruction memory

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// J and JAL always leave, beq only when it compares $zero with itself
	function automatic logic isTaken(instrT word);
		return word[31:26] == `FRONT_OP_J || word[31:26] == `FRONT_OP_JAL ||
			(word[31:26] == `FRONT_OP_BEQ && word[25:16] == '0);
	endfunction

	function automatic addrT targetOf(addrT pc, instrT word);
		addrT slot;
		slot = pc + 32'd4;
		if (word[31:26] == `FRONT_OP_BEQ) begin
			return slot + {{14{word[15]}}, word[15:0], 2'b00};
		end
		return {slot[31:28], word[25:0], 2'b00};
	endfunction

	function automatic decodedT expectedEntry(logic valid, addrT pc, instrT word, logic adEL,
		logic bd);
		decodedT e;
		e = '0;
		if (valid) begin
			e.valid = 1'b1;
			e.pc = pc;
			e.instr = word;
			e.rs = word[25:21];
			e.rt = word[20:16];
			e.rd = word[15:11];
			e.imm32 = {{16{word[15]}}, word[15:0]};
			e.isJump = !adEL && isTaken(word);
			e.isLink = e.isJump && word[31:26] == `FRONT_OP_JAL;
			e.isBD = bd;
			e.adEL = adEL;
		end
		return e;
	endfunction

	task automatic reportFailure(string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic checkValue(string name, logic [127:0] got, logic [127:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			reportFailure("front end output differs from the reference model");
		end
	endtask

	task automatic stepCycles(int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic flushPulse(addrT target);
		flush = 1'b1;
		flushTarget = target;
		stepCycles(1);
		flush = 1'b0;
	endtask

	always @(posedge clk) begin : refModel
		logic taken;
		taken = mIdValid && !mIdAdEL && isTaken(mIdWord);
		if (!rst || flush) begin
			mPc <= rst ? flushTarget : `FRONT_RESET_VEC;
			mIdValid <= 1'b0;
			mBD <= 1'b0;
			expDec <= '0;
		end else if (!stall) begin
			mPc <= taken ? targetOf(mIdPc, mIdWord) : mPc + 32'd4;
			mIdValid <= 1'b1;
			mIdPc <= mPc;
			mIdAdEL <= |mPc[1:0];
			mIdWord <= |mPc[1:0] ? '0 : mem[mPc[9:2]];
			expDec <= expectedEntry(mIdValid, mIdPc, mIdWord, mIdAdEL, mBD);
			if (mIdValid) begin
				mBD <= taken;
			end
		end
	end

	always @(negedge clk) begin
		if (dut_i.props_i.failCount != 0) begin
			reportFailure("a bound assertion on the front end failed");
		end
		if (rst) begin
			checkValue("instrAddr", instrAddr, mPc);
			checkValue("decoded.valid", decoded.valid, expDec.valid);
			checkValue("decoded.pc", decoded.pc, expDec.pc);
			checkValue("decoded.instr", decoded.instr, expDec.instr);
			checkValue("decoded.isBD", decoded.isBD, expDec.isBD);
			checkValue("decoded", decoded, expDec); // rs, rt, rd, imm32 and flags
			seenJump += decoded.valid && decoded.isJump;
			seenLink += decoded.valid && decoded.isLink;
			seenBD += decoded.valid && decoded.isBD;
			seenAdEL += decoded.valid && decoded.adEL;
			seenPlainBeq += decoded.valid && !decoded.isJump &&
				decoded.instr[31:26] == `FRONT_OP_BEQ;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MaxCycles) begin
			reportFailure("timeout: the run did not finish within 400 cycles");
		end
	end

	initial begin : stimulus
		logic [31:0] w;
		rst = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		flushTarget = '0;
		for (int i = 0; i < 256; i++) begin
			w = lcgNext();
			if (w[31:26] inside {6'd2, 6'd3, 6'd4}) begin
				w[31:26] = w[31:26] + 6'd8; // keep random words away from control flow
			end
			mem[i] = w;
		end
		mem[8] = {`FRONT_OP_J, 26'h3f0_0020}; // to bfc00080
		mem[32] = {`FRONT_OP_JAL, 26'h3f0_0040}; // to bfc00100
		mem[64] = {`FRONT_OP_BEQ, 10'd0, 16'd16}; // b to bfc00144
		mem[82] = {`FRONT_OP_BEQ, 5'd3, 5'd5, 16'd8};
		mem[120] = {`FRONT_OP_BEQ, 10'd0, 16'hffe0}; // backward b to bfc00164
		repeat (10) @(posedge clk);
		#1 rst = 1'b1;
		checkValue("instrAddr", instrAddr, `FRONT_RESET_VEC);
		stepCycles(45);
		for (int k = 0; k < 12; k++) begin
			stepCycles(1 + lcgNext() % 3);
			stall = 1'b1;
			stepCycles(1 + lcgNext() % 4);
			stall = 1'b0;
		end
		flushPulse(32'hbfc0_0018);
		stepCycles(12);
		stall = 1'b1; // flush has to win over this stall
		stepCycles(2);
		flushPulse(32'hbfc0_0100);
		stepCycles(2);
		stall = 1'b0;
		stepCycles(10);
		flushPulse(32'hbfc0_0042);
		stepCycles(8);
		flushPulse(`FRONT_RESET_VEC);
		stepCycles(12);
		if (seenJump > 0 && seenLink > 0 && seenBD > 0 && seenAdEL > 0 && seenPlainBeq > 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			reportFailure("a jump, link, delay slot, address error or plain beq was never decoded");
		end
	end

endmodule

`default_nettype wire
